/* hw/lagd_consts.svh */
`ifndef LAGD_CONSTS_SVH
`define LAGD_CONSTS_SVH

// Width of one spin vector in bits
`define LAGD_NUM_SPIN 16

// Entries in the spin FIFO the host loads
`define LAGD_SPIN_DEPTH 4

// Entries in the result FIFO the host drains
`define LAGD_RES_DEPTH 4

// Width of the iteration index and the iteration limit
`define LAGD_ITER_W 8

`endif

/* hw/lagd_pkg.sv */
`default_nettype none

`include "lagd_consts.svh"

package lagd_pkg;

    // One spin vector, one bit per spin
    typedef logic [`LAGD_NUM_SPIN-1:0] spin_t;

    // Iteration index, also used for the configured limit
    typedef logic [`LAGD_ITER_W-1:0] iter_t;

    // Fill level of the spin FIFO, covers 0 up to a full FIFO
    typedef logic [$clog2(`LAGD_SPIN_DEPTH + 1)-1:0] spin_usage_t;

    // Result word, flipped spin in the upper bits and its iteration tag below
    typedef struct packed {
        spin_t spin;
        iter_t iter;
    } result_t;

    // Control FSM states
    typedef enum logic [2:0] {
        IDLE,
        ARM,
        RUN,
        DONE,
        FLUSH
    } anneal_state_e;

endpackage

`default_nettype wire

/* hw/anneal_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface anneal_ctrl_if;

    // Maintainer enable, level
    logic en;
    // Empties the spin FIFO and drops the busy state, one-cycle pulse
    logic flush;
    // Arms the computation, one-cycle pulse
    logic cmpt_en;
    // Lets the host drain the spin FIFO outside a run, level
    logic host_readout;
    // Completion busy level, returned by the maintainer
    logic cmpt_busy;

    // FSM side
    modport ctrl (
        output en,
        output flush,
        output cmpt_en,
        output host_readout,
        input  cmpt_busy
    );

    // Spin FIFO maintainer side
    modport maint (
        input  en,
        input  flush,
        input  cmpt_en,
        input  host_readout,
        output cmpt_busy
    );

endinterface

`default_nettype wire

/* hw/lagd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module lagd_fifo #(
    parameter type         data_t = logic,
    parameter int unsigned DEPTH  = 4
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         push_i,
    input  logic                         push_none_i,
    input  data_t                        data_i,
    input  logic                         pop_i,
    output data_t                        data_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

    // Pointer wide enough to index every entry, count wide enough to reach DEPTH
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    data_t              mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W-1:0]   wr_ptr_nxt;
    logic [PTR_W-1:0]   rd_ptr_nxt;
    logic [CNT_W-1:0]   cnt_q;
    logic               do_push;
    logic               do_pop;

    // Status straight from the count
    assign full_o  = (cnt_q == CNT_W'(DEPTH));
    assign empty_o = (cnt_q == '0);
    assign usage_o = cnt_q;

    // Push into a full FIFO and pop from an empty one are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Circular pointers, wrap at the last entry
    assign wr_ptr_nxt = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
    assign rd_ptr_nxt = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);

    // Head entry is read from storage, no fall-through
    assign data_o = mem_q[rd_ptr_q];

    // Pointers and count, flush empties the FIFO for the next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_nxt;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_nxt;
            end
            // Simultaneous push and pop leaves the count as is
            if (do_push && !do_pop) begin
                cnt_q <= cnt_q + CNT_W'(1);
            end else if (!do_push && do_pop) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    // Storage, a push-none writes the all-zero payload
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_none_i ? data_t'('0) : data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/spin_fifo_maintainer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lagd_consts.svh"

module spin_fifo_maintainer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    anneal_ctrl_if.maint          ctrl,
    input  logic                  icon_finish_i,
    input  logic                  spin_push_valid_i,
    input  lagd_pkg::spin_t       spin_push_i,
    input  logic                  spin_push_none_i,
    output logic                  spin_push_ready_o,
    output logic                  spin_pop_valid_o,
    output lagd_pkg::spin_t       spin_pop_o,
    input  logic                  spin_pop_ready_i,
    output lagd_pkg::spin_usage_t usage_o
);

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;
    logic cmpt_busy_q;
    logic cmpt_stop;
    logic within_cmpt;
    logic busy_set;
    logic busy_clr;

    // Spin storage
    lagd_fifo #(
        .data_t (lagd_pkg::spin_t),
        .DEPTH  (`LAGD_SPIN_DEPTH)
    ) i_spin_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .flush_i     (ctrl.flush),
        .push_i      (fifo_push),
        .push_none_i (spin_push_none_i),
        .data_i      (spin_push_i),
        .pop_i       (fifo_pop),
        .data_o      (spin_pop_o),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .usage_o     (usage_o)
    );

    // Host side handshake
    assign spin_push_ready_o = ~fifo_full;
    assign fifo_push         = spin_push_valid_i & spin_push_ready_o;

    // Run is over once the iterations finished and the host refilled the FIFO
    assign cmpt_stop   = icon_finish_i & fifo_full;
    assign within_cmpt = cmpt_busy_q & ~cmpt_stop;

    // Pops during a live run, or any time the host reads out
    assign spin_pop_valid_o = ctrl.en & ~fifo_empty &
                              ((within_cmpt & ~icon_finish_i) | ctrl.host_readout);
    assign fifo_pop         = spin_pop_valid_o & spin_pop_ready_i;

    // Busy set and clear conditions
    assign busy_set = ctrl.cmpt_en & ctrl.en;
    assign busy_clr = cmpt_stop | ctrl.flush;

    // Completion busy, clear has priority
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmpt_busy_q <= 1'b0;
        end else if (busy_clr) begin
            cmpt_busy_q <= 1'b0;
        end else if (busy_set) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign ctrl.cmpt_busy = cmpt_busy_q;

endmodule

`default_nettype wire

/* hw/anneal_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module anneal_ctrl (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        start_i,
    input  logic        flush_req_i,
    input  logic        readout_i,
    input  logic        icon_finish_i,
    anneal_ctrl_if.ctrl ctrl,
    output logic        cnt_clear_o,
    output logic        run_o
);

    lagd_pkg::anneal_state_e state_q;
    lagd_pkg::anneal_state_e state_d;
    logic                    en_q;
    logic                    host_phase;
    logic                    start_go;

    // States where the host may start a run or read out
    assign host_phase = (state_q == lagd_pkg::IDLE) || (state_q == lagd_pkg::DONE);

    // Accepted start, a pending flush request takes priority
    assign start_go = start_i & ~flush_req_i & host_phase;

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            lagd_pkg::IDLE, lagd_pkg::DONE: begin
                if (flush_req_i) begin
                    state_d = lagd_pkg::FLUSH;
                end else if (start_i) begin
                    state_d = lagd_pkg::ARM;
                end
            end
            // ARM lasts exactly one cycle
            lagd_pkg::ARM: begin
                state_d = flush_req_i ? lagd_pkg::FLUSH : lagd_pkg::RUN;
            end
            // Run until the counter reports all iterations done
            lagd_pkg::RUN: begin
                if (flush_req_i) begin
                    state_d = lagd_pkg::FLUSH;
                end else if (icon_finish_i) begin
                    state_d = lagd_pkg::DONE;
                end
            end
            lagd_pkg::FLUSH: begin
                state_d = lagd_pkg::IDLE;
            end
            default: begin
                state_d = lagd_pkg::IDLE;
            end
        endcase
    end

    // State and registered enable, enable drops only for the flush cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= lagd_pkg::IDLE;
            en_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            en_q    <= (state_d != lagd_pkg::FLUSH);
        end
    end

    // Control outputs decoded from the state
    assign ctrl.en           = en_q;
    assign ctrl.flush        = (state_q == lagd_pkg::FLUSH);
    assign ctrl.cmpt_en      = (state_q == lagd_pkg::ARM);
    assign ctrl.host_readout = readout_i & host_phase;

    // Counter is clear by the ARM cycle, so a stale finish level
    // cannot block the busy set in the maintainer
    assign cnt_clear_o = start_go | (state_q == lagd_pkg::FLUSH);
    assign run_o       = (state_q == lagd_pkg::RUN);

endmodule

`default_nettype wire

/* hw/iter_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module iter_counter (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            clear_i,
    input  logic            run_i,
    input  logic            step_i,
    input  lagd_pkg::iter_t limit_i,
    output lagd_pkg::iter_t count_o,
    output logic            icon_finish_o
);

    lagd_pkg::iter_t count_q;
    lagd_pkg::iter_t count_inc;
    logic            finish_q;
    logic            do_step;

    // Only steps during a run that has not finished yet
    assign do_step   = run_i & step_i & ~finish_q;
    assign count_inc = count_q + lagd_pkg::iter_t'(1);

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            count_q  <= '0;
            finish_q <= 1'b0;
        end else if (do_step) begin
            count_q  <= count_inc;
            // A zero limit never finishes
            finish_q <= (count_inc == limit_i) && (limit_i != '0);
        end
    end

    assign count_o       = count_q;
    assign icon_finish_o = finish_q;

endmodule

`default_nettype wire

/* hw/spin_flip_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module spin_flip_engine (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              run_i,
    input  lagd_pkg::spin_t   flip_mask_i,
    input  lagd_pkg::iter_t   iter_i,
    input  logic              spin_valid_i,
    input  lagd_pkg::spin_t   spin_i,
    output logic              spin_ready_o,
    output logic              res_valid_o,
    output lagd_pkg::result_t res_o,
    input  logic              res_ready_i,
    output logic              step_o
);

    logic              valid_q;
    lagd_pkg::result_t res_q;
    logic              accept;

    // Stage takes a new spin when empty or when its result leaves this cycle
    assign spin_ready_o = ~valid_q | res_ready_i;
    assign accept       = spin_valid_i & spin_ready_o;

    // One iteration per spin taken during a run
    assign step_o = accept & run_i;

    // Stage valid
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Payload, flipped and tagged in a run, passed through untagged in readout
    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q.spin <= run_i ? (spin_i ^ flip_mask_i) : spin_i;
            res_q.iter <= run_i ? iter_i : '0;
        end
    end

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

endmodule

`default_nettype wire

/* hw/lagd_spin_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lagd_consts.svh"

module lagd_spin_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  logic                  flush_req_i,
    input  logic                  readout_i,
    input  lagd_pkg::spin_t       flip_mask_i,
    input  lagd_pkg::iter_t       iter_limit_i,
    input  logic                  spin_push_valid_i,
    input  lagd_pkg::spin_t       spin_push_i,
    input  logic                  spin_push_none_i,
    output logic                  spin_push_ready_o,
    output logic                  res_valid_o,
    output lagd_pkg::result_t     res_o,
    input  logic                  res_ready_i,
    output logic                  cmpt_busy_o,
    output logic                  icon_finish_o,
    output lagd_pkg::spin_usage_t spin_usage_o
);

    // FSM to maintainer controls
    anneal_ctrl_if ctrl_if ();

    logic              cnt_clear;
    logic              run;
    logic              icon_finish;
    logic              step;
    lagd_pkg::iter_t   iter_count;
    logic              spin_pop_valid;
    lagd_pkg::spin_t   spin_pop;
    logic              spin_pop_ready;
    logic              eng_valid;
    lagd_pkg::result_t eng_res;
    logic              res_full;
    logic              res_empty;

    anneal_ctrl i_anneal_ctrl (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .flush_req_i   (flush_req_i),
        .readout_i     (readout_i),
        .icon_finish_i (icon_finish),
        .ctrl          (ctrl_if.ctrl),
        .cnt_clear_o   (cnt_clear),
        .run_o         (run)
    );

    spin_fifo_maintainer i_spin_fifo_maintainer (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .ctrl              (ctrl_if.maint),
        .icon_finish_i     (icon_finish),
        .spin_push_valid_i (spin_push_valid_i),
        .spin_push_i       (spin_push_i),
        .spin_push_none_i  (spin_push_none_i),
        .spin_push_ready_o (spin_push_ready_o),
        .spin_pop_valid_o  (spin_pop_valid),
        .spin_pop_o        (spin_pop),
        .spin_pop_ready_i  (spin_pop_ready),
        .usage_o           (spin_usage_o)
    );

    iter_counter i_iter_counter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .clear_i       (cnt_clear),
        .run_i         (run),
        .step_i        (step),
        .limit_i       (iter_limit_i),
        .count_o       (iter_count),
        .icon_finish_o (icon_finish)
    );

    // Result FIFO not-full is the engine's ready
    spin_flip_engine i_spin_flip_engine (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .run_i        (run),
        .flip_mask_i  (flip_mask_i),
        .iter_i       (iter_count),
        .spin_valid_i (spin_pop_valid),
        .spin_i       (spin_pop),
        .spin_ready_o (spin_pop_ready),
        .res_valid_o  (eng_valid),
        .res_o        (eng_res),
        .res_ready_i  (~res_full),
        .step_o       (step)
    );

    // Results wait here for the host, flushed together with the spins
    lagd_fifo #(
        .data_t (lagd_pkg::result_t),
        .DEPTH  (`LAGD_RES_DEPTH)
    ) i_res_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .flush_i     (ctrl_if.flush),
        .push_i      (eng_valid),
        .push_none_i (1'b0),
        .data_i      (eng_res),
        .pop_i       (res_ready_i),
        .data_o      (res_o),
        .full_o      (res_full),
        .empty_o     (res_empty),
        .usage_o     ()
    );

    assign res_valid_o   = ~res_empty;
    assign cmpt_busy_o   = ctrl_if.cmpt_busy;
    assign icon_finish_o = icon_finish;

endmodule

`default_nettype wire

/* dv/lagd_spin_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lagd_consts.svh"

module lagd_spin_checker (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  push_i,
    input logic                  full_i,
    input logic                  pop_valid_i,
    input logic                  busy_i,
    input logic                  flush_i,
    input logic                  finish_i,
    input lagd_pkg::spin_usage_t usage_i
);

    // Push request on a full FIFO must not raise the fill level
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        (push_i && full_i) |=> (usage_i <= $past(usage_i)))
        else $error("spin FIFO accepted a push while full");

    // Never offer a spin that is not there, judged by the fill level
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_valid_i |-> (usage_i != '0))
        else $error("spin pop valid raised while the spin FIFO is empty");

    // Busy drops only after a flush or after finish with every entry taken
    a_busy_fall: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(busy_i) |-> $past(flush_i ||
            (finish_i && (usage_i == lagd_pkg::spin_usage_t'(`LAGD_SPIN_DEPTH)))))
        else $error("completion busy fell without flush or finish on a full FIFO");

    // Fill level stays in range
    a_usage_range: assert property (@(posedge clk_i) disable iff (reset_i)
        usage_i <= lagd_pkg::spin_usage_t'(`LAGD_SPIN_DEPTH))
        else $error("spin FIFO usage above its depth");

endmodule

`default_nettype wire

/* dv/lagd_spin_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lagd_consts.svh"

module lagd_spin_tb;

    localparam int TIMEOUT    = 200;
    localparam int SPIN_DEPTH = `LAGD_SPIN_DEPTH;
    localparam int NUM_SPIN   = `LAGD_NUM_SPIN;

    logic                  clk_i;
    logic                  reset_i;
    logic                  start_i;
    logic                  flush_req_i;
    logic                  readout_i;
    lagd_pkg::spin_t       flip_mask_i;
    lagd_pkg::iter_t       iter_limit_i;
    logic                  spin_push_valid_i;
    lagd_pkg::spin_t       spin_push_i;
    logic                  spin_push_none_i;
    logic                  spin_push_ready_o;
    logic                  res_valid_o;
    lagd_pkg::result_t     res_o;
    logic                  res_ready_i;
    logic                  cmpt_busy_o;
    logic                  icon_finish_o;
    lagd_pkg::spin_usage_t spin_usage_o;

    logic [31:0]           lfsr_q;
    // Model state, spins in the FIFO and results expected and seen
    lagd_pkg::spin_t       spin_model[$];
    lagd_pkg::result_t     exp_q[$];
    lagd_pkg::result_t     got_q[$];
    int                    err_cnt;
    int                    chk_cnt;
    int                    test_err;
    int                    tests_run;

    lagd_spin_top i_lagd_spin_top (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .start_i           (start_i),
        .flush_req_i       (flush_req_i),
        .readout_i         (readout_i),
        .flip_mask_i       (flip_mask_i),
        .iter_limit_i      (iter_limit_i),
        .spin_push_valid_i (spin_push_valid_i),
        .spin_push_i       (spin_push_i),
        .spin_push_none_i  (spin_push_none_i),
        .spin_push_ready_o (spin_push_ready_o),
        .res_valid_o       (res_valid_o),
        .res_o             (res_o),
        .res_ready_i       (res_ready_i),
        .cmpt_busy_o       (cmpt_busy_o),
        .icon_finish_o     (icon_finish_o),
        .spin_usage_o      (spin_usage_o)
    );

    // Assertions on the spin FIFO maintainer
    bind spin_fifo_maintainer lagd_spin_checker i_lagd_spin_checker (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (spin_push_valid_i),
        .full_i      (fifo_full),
        .pop_valid_i (spin_pop_valid_o),
        .busy_i      (cmpt_busy_q),
        .flush_i     (ctrl.flush),
        .finish_i    (icon_finish_i),
        .usage_i     (usage_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Inputs only move at rising edges, so the falling edge sees the coming transfer
    always @(negedge clk_i) begin
        if (!reset_i && res_valid_o && res_ready_i) begin
            got_q.push_back(res_o);
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic lagd_pkg::result_t make_result(input lagd_pkg::spin_t s,
                                                      input lagd_pkg::iter_t it);
        lagd_pkg::result_t r;
        r.spin = s;
        r.iter = it;
        return r;
    endfunction

    task automatic check_result(input lagd_pkg::result_t got, input lagd_pkg::result_t exp,
                                input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s, got %h/%0d, expected %h/%0d", $time, msg,
                     got.spin, got.iter, exp.spin, exp.iter);
        end
    endtask

    task automatic check_spin(input lagd_pkg::spin_t got, input lagd_pkg::spin_t exp,
                              input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_usage(input lagd_pkg::spin_usage_t got,
                               input lagd_pkg::spin_usage_t exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        err_cnt++;
        $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
    endtask

    // Offer one spin and hold it until the FIFO takes it
    task automatic push_spin(input lagd_pkg::spin_t s, input logic none);
        int t;
        t = 0;
        spin_push_valid_i <= 1'b1;
        spin_push_i       <= s;
        spin_push_none_i  <= none;
        @(negedge clk_i);
        while (!spin_push_ready_o && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        @(posedge clk_i);
        spin_push_valid_i <= 1'b0;
        spin_push_none_i  <= 1'b0;
        if (t >= TIMEOUT) begin
            report_timeout("spin push accept");
        end else begin
            spin_model.push_back(none ? lagd_pkg::spin_t'(0) : s);
        end
    endtask

    // Push random spins until ready drops, last one optionally a push-none
    task automatic fill_spins(input logic none_last);
        int   n;
        logic last;
        n = 0;
        @(negedge clk_i);
        while (spin_push_ready_o && n < 2 * SPIN_DEPTH) begin
            last = (spin_usage_o == lagd_pkg::spin_usage_t'(SPIN_DEPTH - 1));
            @(posedge clk_i);
            push_spin(lagd_pkg::spin_t'(rand_bits(NUM_SPIN)), none_last & last);
            @(negedge clk_i);
            n++;
        end
        @(posedge clk_i);
    endtask

    task automatic pulse_start();
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
    endtask

    task automatic pulse_flush();
        flush_req_i <= 1'b1;
        @(posedge clk_i);
        flush_req_i <= 1'b0;
    endtask

    // Random ready pattern when asked for, ready high again afterwards
    task automatic wait_results(input int n, input logic rnd_ready);
        int          t;
        logic [31:0] r;
        t = 0;
        while (got_q.size() < n && t < TIMEOUT) begin
            if (rnd_ready) begin
                r = rand_bits(1);
                res_ready_i <= r[0];
            end
            @(posedge clk_i);
            t++;
        end
        res_ready_i <= 1'b1;
        if (t >= TIMEOUT) begin
            report_timeout($sformatf("arrival of %0d results", n));
        end
    endtask

    task automatic wait_busy_low();
        int t;
        t = 0;
        @(negedge clk_i);
        while (cmpt_busy_o && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        @(posedge clk_i);
        if (t >= TIMEOUT) begin
            report_timeout("completion busy clear");
        end
    endtask

    task automatic wait_usage_zero();
        int t;
        t = 0;
        @(negedge clk_i);
        while (spin_usage_o != '0 && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        @(posedge clk_i);
        if (t >= TIMEOUT) begin
            report_timeout("spin FIFO empty");
        end
    endtask

    // Short window to catch extra results, then compare in order
    task automatic compare_results(input string what);
        int n;
        repeat (8) @(posedge clk_i);
        check_flag(got_q.size() == exp_q.size(), 1'b1,
                   $sformatf("%s result count %0d vs %0d", what, got_q.size(), exp_q.size()));
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_result(got_q[i], exp_q[i], $sformatf("%s result %0d", what, i));
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %s", num, name, (err_cnt == test_err) ? "ok" : "errors seen");
        test_err = err_cnt;
        tests_run++;
    endtask

    // Sets a random mask and limit, predicts the run and starts it
    task automatic start_run(output int limit);
        lagd_pkg::spin_t mask;
        mask  = lagd_pkg::spin_t'(rand_bits(NUM_SPIN));
        limit = int'(rand_bits(2)) + 1;
        flip_mask_i  <= mask;
        iter_limit_i <= lagd_pkg::iter_t'(limit);
        for (int i = 0; i < limit; i++) begin
            exp_q.push_back(make_result(spin_model.pop_front() ^ mask, lagd_pkg::iter_t'(i)));
        end
        pulse_start();
    endtask

    initial begin
        int limit;
        int n;
        lfsr_q            = 32'h599a97dd;
        err_cnt           = 0;
        chk_cnt           = 0;
        test_err          = 0;
        tests_run         = 0;
        reset_i           = 1'b1;
        start_i           = 1'b0;
        flush_req_i       = 1'b0;
        readout_i         = 1'b0;
        flip_mask_i       = '0;
        iter_limit_i      = '0;
        spin_push_valid_i = 1'b0;
        spin_push_i       = '0;
        spin_push_none_i  = 1'b0;
        res_ready_i       = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_i     <= 1'b0;
        res_ready_i <= 1'b1;

        // Reset values, then a full FIFO that stays put while idle
        @(negedge clk_i);
        check_flag(res_valid_o, 1'b0, "result valid after reset");
        check_flag(cmpt_busy_o, 1'b0, "busy after reset");
        check_flag(icon_finish_o, 1'b0, "finish after reset");
        check_usage(spin_usage_o, '0, "usage after reset");
        @(posedge clk_i);
        fill_spins(1'b0);
        @(negedge clk_i);
        check_usage(spin_usage_o, lagd_pkg::spin_usage_t'(SPIN_DEPTH), "usage when full");
        check_flag(spin_push_ready_o, 1'b0, "push ready when full");
        @(posedge clk_i);
        repeat (8) @(posedge clk_i);
        check_flag(got_q.size() == 0, 1'b1, "no results while idle");
        end_test(1, "fill and usage");

        start_run(limit);
        wait_results(limit, 1'b0);
        compare_results("run");
        @(negedge clk_i);
        check_flag(icon_finish_o, 1'b1, "finish after run");
        check_flag(cmpt_busy_o, 1'b1, "busy after run");
        @(posedge clk_i);
        end_test(2, "annealing run");

        // Refill ends with a push-none that shows up in the readout
        fill_spins(1'b1);
        wait_busy_low();
        repeat (8) @(posedge clk_i);
        check_flag(got_q.size() == 0, 1'b1, "no results after refill");
        end_test(3, "busy clear");

        readout_i <= 1'b1;
        while (spin_model.size() > 0) begin
            exp_q.push_back(make_result(spin_model.pop_front(), '0));
        end
        n = exp_q.size();
        wait_results(n, 1'b0);
        wait_usage_zero();
        if (got_q.size() > 0) begin
            check_spin(got_q[got_q.size() - 1].spin, '0, "push-none entry read out");
        end
        compare_results("readout");
        readout_i <= 1'b0;
        @(posedge clk_i);
        end_test(4, "readout");

        fill_spins(1'b0);
        start_run(limit);
        wait_results(limit, 1'b1);
        compare_results("back-pressure run");
        @(negedge clk_i);
        check_flag(icon_finish_o, 1'b1, "finish after back-pressure run");
        @(posedge clk_i);
        end_test(5, "back-pressure");

        push_spin(lagd_pkg::spin_t'(rand_bits(NUM_SPIN)), 1'b0);
        pulse_flush();
        wait_usage_zero();
        spin_model.delete();
        @(negedge clk_i);
        check_flag(cmpt_busy_o, 1'b0, "busy after flush");
        check_flag(icon_finish_o, 1'b0, "finish after flush");
        @(posedge clk_i);
        readout_i <= 1'b1;
        repeat (8) @(posedge clk_i);
        readout_i <= 1'b0;
        check_flag(got_q.size() == 0, 1'b1, "no results after flush");
        end_test(6, "flush");

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/lagd_pkg.sv
hw/anneal_ctrl_if.sv
hw/lagd_fifo.sv
hw/spin_fifo_maintainer.sv
hw/anneal_ctrl.sv
hw/iter_counter.sv
hw/spin_flip_engine.sv
hw/lagd_spin_top.sv
dv/lagd_spin_checker.sv
dv/lagd_spin_tb.sv

/* Bender.yml */
package:
  name: lagd_spin

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lagd_pkg.sv
      - hw/anneal_ctrl_if.sv
      - hw/lagd_fifo.sv
      - hw/spin_fifo_maintainer.sv
      - hw/anneal_ctrl.sv
      - hw/iter_counter.sv
      - hw/spin_flip_engine.sv
      - hw/lagd_spin_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/lagd_spin_checker.sv
      - dv/lagd_spin_tb.sv
